//--- hw/gemm_params.svh
// GEMM tile parameters.
// Tile geometry, element widths and the Wishbone register word map.

`ifndef GEMM_PARAMS_SVH
`define GEMM_PARAMS_SVH

// Tile geometry, fixed by the register map to 4x4.
`define MAC_HEIGHT 4
`define MAC_DEPTH  4

// Element and accumulator widths.
`define ELEM_W 16
`define ACC_W  32

// Word address bits decoded by the bus slave.
`define WB_AW 4

// Register word addresses.
`define REG_CTRL   0
`define REG_CFG    1
`define REG_W_LO   2
`define REG_W_HI   3
`define REG_X_LO   4
`define REG_X_HI   5
`define REG_STATUS 6
`define REG_Z0     8

`endif

//--- hw/gemm_pkg.sv
// GEMM tile package.
// Shared data types of the matrix-vector tile and the controller states.

`include "gemm_params.svh"

package gemm_pkg;

  // One signed tile element.
  typedef logic signed [`ELEM_W-1:0] elem_t;

  // One accumulator lane, also the result word.
  typedef logic signed [`ACC_W-1:0] acc_t;

  // A full weight row, column 0 in the low bits.
  typedef logic [`MAC_DEPTH*`ELEM_W-1:0] wrow_t;

  // Leftover or row count, 0 to 4.
  // A leftover of zero selects the full tile size.
  typedef logic [2:0] lftovr_t;

  // Controller states.
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } ctrl_state_e;

endpackage

//--- hw/gemm_w_buffer.sv
// GEMM weight buffer.
// Holds the weight tile, loads one row per load pulse into the slot picked
// by an internal row counter and shifts all rows toward column 0.
// Rows and columns beyond the leftovers are filled with zeros.
// The output is column 0 of every row.

`include "gemm_params.svh"

module gemm_w_buffer
  import gemm_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  logic                      load_i,
  input  logic                      shift_i,
  input  lftovr_t                   rows_lftovr_i,
  input  lftovr_t                   cols_lftovr_i,
  input  wrow_t                     w_row_i,
  output elem_t [`MAC_HEIGHT-1:0]   w_col_o,
  output lftovr_t                   rows_loaded_o
);

  // Stored tile, indexed [row][column].
  elem_t [`MAC_HEIGHT-1:0][`MAC_DEPTH-1:0] w_q;
  // Tile shifted by one column, zero entering at the far end.
  elem_t [`MAC_HEIGHT-1:0][`MAC_DEPTH-1:0] w_shifted;

  lftovr_t w_row_q;
  lftovr_t depth;
  lftovr_t count_limit;

  // Zero leftover means full size.
  assign depth       = (cols_lftovr_i == '0) ? lftovr_t'(`MAC_DEPTH) : cols_lftovr_i;
  assign count_limit = (rows_lftovr_i == '0) ? lftovr_t'(`MAC_HEIGHT) : rows_lftovr_i;

  always_comb begin
    for (int h = 0; h < `MAC_HEIGHT; h++) begin
      for (int d = 0; d < `MAC_DEPTH - 1; d++) begin
        w_shifted[h][d] = w_q[h][d+1];
      end
      w_shifted[h][`MAC_DEPTH-1] = '0;
    end
  end

  // Tile storage. Clear wins over load and shift.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_q <= '0;
    end else if (clear_i) begin
      w_q <= '0;
    end else begin
      for (int h = 0; h < `MAC_HEIGHT; h++) begin
        for (int d = 0; d < `MAC_DEPTH; d++) begin
          if (load_i && (h == w_row_q)) begin
            // Masked copy of the incoming row.
            w_q[h][d] <= (d < depth && w_row_q < count_limit) ?
                         w_row_i[d*`ELEM_W +: `ELEM_W] : '0;
          end else if (shift_i) begin
            w_q[h][d] <= w_shifted[h][d];
          end
        end
      end
    end
  end

  // Row counter, holds MAC_HEIGHT for one cycle before wrapping.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_row_q <= '0;
    end else if (clear_i || w_row_q == lftovr_t'(`MAC_HEIGHT)) begin
      w_row_q <= '0;
    end else if (load_i) begin
      w_row_q <= w_row_q + lftovr_t'(1);
    end
  end

  for (genvar h = 0; h < `MAC_HEIGHT; h++) begin : g_out
    assign w_col_o[h] = w_q[h][0];
  end

  assign rows_loaded_o = w_row_q;

  // Row slot index stays inside the tile plus the one-cycle wrap value.
  a_row_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_row_q <= lftovr_t'(`MAC_HEIGHT));

endmodule

//--- hw/gemm_mac_array.sv
// GEMM MAC array.
// MAC_HEIGHT signed multiply-accumulate lanes. Each lane multiplies its
// weight element by the broadcast X element and accumulates modulo 2^32.

`include "gemm_params.svh"

module gemm_mac_array
  import gemm_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      acc_en_i,
  input  logic                      acc_clr_i,
  input  elem_t [`MAC_HEIGHT-1:0]   w_col_i,
  input  elem_t                     x_elem_i,
  output acc_t  [`MAC_HEIGHT-1:0]   z_o
);

  acc_t [`MAC_HEIGHT-1:0] acc_q;
  acc_t [`MAC_HEIGHT-1:0] prod;

  for (genvar h = 0; h < `MAC_HEIGHT; h++) begin : g_lane
    // Full signed product, fits the accumulator width.
    assign prod[h] = acc_t'($signed(w_col_i[h]) * $signed(x_elem_i));

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        acc_q[h] <= '0;
      end else if (acc_en_i) begin
        // First step of a run starts a fresh sum.
        if (acc_clr_i) begin
          acc_q[h] <= prod[h];
        end else begin
          acc_q[h] <= acc_q[h] + prod[h];
        end
      end
    end
  end

  assign z_o = acc_q;

  // The restart marker is only meaningful on an accumulate step.
  a_clr_with_en: assert property (@(posedge clk_i) disable iff (!rst_ni)
    acc_clr_i |-> acc_en_i);

endmodule

//--- hw/gemm_ctrl.sv
// GEMM controller.
// Runs one computation of MAC_DEPTH shift-and-accumulate steps per start
// and selects the X element for each step. Done holds until the next start.

`include "gemm_params.svh"

module gemm_ctrl
  import gemm_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      start_i,
  input  elem_t [`MAC_DEPTH-1:0]    x_vec_i,
  output logic                      w_shift_o,
  output logic                      acc_en_o,
  output logic                      acc_clr_o,
  output elem_t                     x_elem_o,
  output logic                      busy_o,
  output logic                      done_o
);

  ctrl_state_e state_q, state_d;
  logic [$clog2(`MAC_DEPTH)-1:0] step_q, step_d;

  always_comb begin
    state_d = state_q;
    step_d  = step_q;
    unique case (state_q)
      IDLE, DONE: begin
        // A start from idle or done begins a new run.
        if (start_i) begin
          state_d = RUN;
          step_d  = '0;
        end
      end
      RUN: begin
        // Start is ignored while running.
        step_d = step_q + 1'b1;
        if (step_q == `MAC_DEPTH - 1) begin
          state_d = DONE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      step_q  <= '0;
    end else begin
      state_q <= state_d;
      step_q  <= step_d;
    end
  end

  // Every RUN cycle shifts the buffer and accumulates one column.
  assign w_shift_o = (state_q == RUN);
  assign acc_en_o  = (state_q == RUN);
  assign acc_clr_o = (state_q == RUN) && (step_q == '0);
  assign x_elem_o  = x_vec_i[step_q];

  assign busy_o = (state_q == RUN);
  assign done_o = (state_q == DONE);

  // Shifts come as one burst of MAC_DEPTH RUN cycles, then DONE.
  a_shift_in_run: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(w_shift_o) |-> (state_q == RUN) [*`MAC_DEPTH] ##1 (state_q == DONE));

endmodule

//--- hw/gemm_wb_regs.sv
// GEMM Wishbone register slave.
// Classic single-cycle-ack slave with the tile register map. Holds the
// configuration, the staged low half of a weight row and the X vector,
// turns CTRL writes into pulses and issues a weight load on each W_HI write.

`include "gemm_params.svh"

module gemm_wb_regs
  import gemm_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  logic [`WB_AW-1:0]         wb_adr_i,
  input  logic [31:0]               wb_dat_i,
  input  logic [3:0]                wb_sel_i,
  output logic [31:0]               wb_dat_o,
  output logic                      wb_ack_o,
  input  logic                      busy_i,
  input  logic                      done_i,
  input  lftovr_t                   rows_loaded_i,
  input  acc_t  [`MAC_HEIGHT-1:0]   z_i,
  output logic                      start_o,
  output logic                      clear_o,
  output logic                      w_load_o,
  output wrow_t                     w_row_o,
  output elem_t [`MAC_DEPTH-1:0]    x_vec_o,
  output lftovr_t                   rows_lftovr_o,
  output lftovr_t                   cols_lftovr_o
);

  logic        ack_q;
  logic        req;
  logic        wr;
  logic [31:0] rdata;
  logic [31:0] dat_q;
  logic [31:0] w_lo_q;
  logic        start_q;
  logic        clear_q;
  lftovr_t     rows_lftovr_q;
  lftovr_t     cols_lftovr_q;
  logic [`WB_AW-1:0] z_idx;
  elem_t [`MAC_DEPTH-1:0] x_q;

  // A new transfer is acknowledged on the coming edge.
  assign req = wb_cyc_i && wb_stb_i && !ack_q;
  // Byte selects are ignored.
  assign wr  = req && wb_we_i;

  // Weight load fires on the acking edge and is dropped while busy.
  assign w_load_o = wr && (wb_adr_i == `REG_W_HI) && !busy_i;
  assign w_row_o  = {wb_dat_i, w_lo_q};

  assign z_idx = wb_adr_i - `REG_Z0;

  // Read mux.
  always_comb begin
    rdata = '0;
    case (wb_adr_i)
      `REG_CFG:    rdata = {21'b0, cols_lftovr_q, 5'b0, rows_lftovr_q};
      `REG_X_LO:   rdata = {x_q[1], x_q[0]};
      `REG_X_HI:   rdata = {x_q[3], x_q[2]};
      `REG_STATUS: rdata = {25'b0, rows_loaded_i, 2'b0, done_i, busy_i};
      default: begin
        // Result window.
        if (wb_adr_i >= `REG_Z0 && wb_adr_i < `REG_Z0 + `MAC_HEIGHT) begin
          rdata = z_i[z_idx[$clog2(`MAC_HEIGHT)-1:0]];
        end
      end
    endcase
  end

  // Bus handshake and read data.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
      dat_q <= '0;
    end else begin
      ack_q <= req;
      if (req && !wb_we_i) begin
        dat_q <= rdata;
      end
    end
  end

  // Register writes and command pulses.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q       <= 1'b0;
      clear_q       <= 1'b0;
      rows_lftovr_q <= '0;
      cols_lftovr_q <= '0;
      w_lo_q        <= '0;
      x_q           <= '0;
    end else begin
      start_q <= wr && (wb_adr_i == `REG_CTRL) && wb_dat_i[0];
      clear_q <= wr && (wb_adr_i == `REG_CTRL) && wb_dat_i[1];
      if (wr) begin
        case (wb_adr_i)
          `REG_CFG: begin
            rows_lftovr_q <= wb_dat_i[2:0];
            cols_lftovr_q <= wb_dat_i[10:8];
          end
          `REG_W_LO: w_lo_q <= wb_dat_i;
          `REG_X_LO: begin
            x_q[0] <= wb_dat_i[15:0];
            x_q[1] <= wb_dat_i[31:16];
          end
          `REG_X_HI: begin
            x_q[2] <= wb_dat_i[15:0];
            x_q[3] <= wb_dat_i[31:16];
          end
          default: ;
        endcase
      end
    end
  end

  assign wb_ack_o      = ack_q;
  assign wb_dat_o      = dat_q;
  assign start_o       = start_q;
  assign clear_o       = clear_q;
  assign x_vec_o       = x_q;
  assign rows_lftovr_o = rows_lftovr_q;
  assign cols_lftovr_o = cols_lftovr_q;

  // Each transfer gets exactly one ack cycle.
  a_ack_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_o |=> !wb_ack_o);

endmodule

//--- hw/gemm_top.sv
// GEMM tile top level.
// Wishbone slave, controller, weight buffer and MAC array of a 4x4
// integer matrix-vector tile.

`include "gemm_params.svh"

module gemm_top
  import gemm_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  logic [`WB_AW-1:0] wb_adr_i,
  input  logic [31:0]       wb_dat_i,
  input  logic [3:0]        wb_sel_i,
  output logic [31:0]       wb_dat_o,
  output logic              wb_ack_o
);

  // Slave commands and configuration.
  logic    start, clear, w_load;
  wrow_t   w_row;
  lftovr_t rows_lftovr, cols_lftovr;
  elem_t [`MAC_DEPTH-1:0] x_vec;

  // Controller strobes.
  logic  w_shift, acc_en, acc_clr, busy, done;
  elem_t x_elem;

  // Datapath.
  elem_t [`MAC_HEIGHT-1:0] w_col;
  acc_t  [`MAC_HEIGHT-1:0] z;
  lftovr_t rows_loaded;

  gemm_wb_regs u_regs (
    .clk_i, .rst_ni,
    .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_sel_i,
    .wb_dat_o, .wb_ack_o,
    .busy_i(busy), .done_i(done), .rows_loaded_i(rows_loaded), .z_i(z),
    .start_o(start), .clear_o(clear), .w_load_o(w_load), .w_row_o(w_row),
    .x_vec_o(x_vec), .rows_lftovr_o(rows_lftovr), .cols_lftovr_o(cols_lftovr)
  );

  gemm_ctrl u_ctrl (
    .clk_i, .rst_ni,
    .start_i(start), .x_vec_i(x_vec),
    .w_shift_o(w_shift), .acc_en_o(acc_en), .acc_clr_o(acc_clr),
    .x_elem_o(x_elem), .busy_o(busy), .done_o(done)
  );

  gemm_w_buffer u_w_buffer (
    .clk_i, .rst_ni,
    .clear_i(clear), .load_i(w_load), .shift_i(w_shift),
    .rows_lftovr_i(rows_lftovr), .cols_lftovr_i(cols_lftovr),
    .w_row_i(w_row), .w_col_o(w_col), .rows_loaded_o(rows_loaded)
  );

  gemm_mac_array u_mac (
    .clk_i, .rst_ni,
    .acc_en_i(acc_en), .acc_clr_i(acc_clr),
    .w_col_i(w_col), .x_elem_i(x_elem), .z_o(z)
  );

endmodule

//--- bench/gemm_tb.sv
// GEMM tile testbench.
// Directed tests over the Wishbone port of the 4x4 matrix-vector tile.
// Expected results come from a software sum of products per row.

`include "gemm_params.svh"

module gemm_tb
  import gemm_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 8;
  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 200;
  localparam int ACK_LIMIT       = 4;
  localparam int POLL_LIMIT      = 16;
  localparam int WATCHDOG_NS     = (NUM_TESTS * CYCLES_PER_TEST + RESET_CYCLES) * CLK_PERIOD;

  logic              clk_i;
  logic              rst_ni;
  logic              wb_cyc_i;
  logic              wb_stb_i;
  logic              wb_we_i;
  logic [`WB_AW-1:0] wb_adr_i;
  logic [31:0]       wb_dat_i;
  logic [3:0]        wb_sel_i;
  logic [31:0]       wb_dat_o;
  logic              wb_ack_o;

  // Stimulus tile, X vector and expected results.
  elem_t w_tile [`MAC_HEIGHT][`MAC_DEPTH];
  elem_t x_vec [`MAC_DEPTH];
  acc_t  z_exp [`MAC_HEIGHT];
  int    errors;

  gemm_top UUT (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Ends a run that hangs.
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired: the tests did not finish in the allowed time.");
    $display("TB FAILED");
    $fatal(1, "Run stopped by the watchdog.");
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("TB FAILED");
    $fatal(1, "Run stopped at the first error.");
  endtask

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string msg);
    if (actual !== expected) begin
      errors++;
      fail_run($sformatf("mismatch at time %0t: %s, got %h, expected %h",
                         $time, msg, actual, expected));
    end
  endtask

  // Single classic write. Called and returns 2 ns after a rising edge.
  task automatic wb_write(input int adr, input logic [31:0] dat);
    int n;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b1;
    wb_adr_i = adr[`WB_AW-1:0];
    wb_dat_i = dat;
    n = 0;
    do begin
      @(posedge clk_i);
      #2;
      n++;
    end while (!wb_ack_o && n < ACK_LIMIT);
    if (!wb_ack_o) fail_run($sformatf("No bus acknowledge for the write to word %0d.", adr));
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  // Single classic read. Data is valid with ack.
  task automatic wb_read(input int adr, output logic [31:0] dat);
    int n;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b0;
    wb_adr_i = adr[`WB_AW-1:0];
    n = 0;
    do begin
      @(posedge clk_i);
      #2;
      n++;
    end while (!wb_ack_o && n < ACK_LIMIT);
    if (!wb_ack_o) fail_run($sformatf("No bus acknowledge for the read of word %0d.", adr));
    dat = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
  endtask

  task automatic randomize_operands();
    for (int h = 0; h < `MAC_HEIGHT; h++) begin
      for (int d = 0; d < `MAC_DEPTH; d++) begin
        w_tile[h][d] = 16'($urandom());
      end
    end
    for (int d = 0; d < `MAC_DEPTH; d++) begin
      x_vec[d] = 16'($urandom());
    end
  endtask

  // One row per W_LO and W_HI pair.
  task automatic load_tile(input int rows);
    for (int h = 0; h < rows; h++) begin
      wb_write(`REG_W_LO, {w_tile[h][1], w_tile[h][0]});
      wb_write(`REG_W_HI, {w_tile[h][3], w_tile[h][2]});
    end
  endtask

  task automatic set_x();
    wb_write(`REG_X_LO, {x_vec[1], x_vec[0]});
    wb_write(`REG_X_HI, {x_vec[3], x_vec[2]});
  endtask

  // Polls STATUS until done is set and busy is clear.
  task automatic wait_done();
    logic [31:0] status;
    int polls;
    status = '0;
    polls = 0;
    while (!(status[1] && !status[0]) && polls < POLL_LIMIT) begin
      wb_read(`REG_STATUS, status);
      polls++;
    end
    if (!(status[1] && !status[0])) fail_run("The tile did not report done after a start.");
  endtask

  task automatic run_and_wait();
    wb_write(`REG_CTRL, 32'h1);
    wait_done();
  endtask

  // Signed sum of products over the rows and columns inside the leftovers.
  // A zero leftover means the full size.
  task automatic model_z(input int rows_lo, input int cols_lo);
    int   rows;
    int   cols;
    acc_t sum;
    rows = (rows_lo == 0) ? `MAC_HEIGHT : rows_lo;
    cols = (cols_lo == 0) ? `MAC_DEPTH : cols_lo;
    for (int h = 0; h < `MAC_HEIGHT; h++) begin
      sum = '0;
      for (int d = 0; d < `MAC_DEPTH; d++) begin
        if (h < rows && d < cols) sum += acc_t'(w_tile[h][d]) * acc_t'(x_vec[d]);
      end
      z_exp[h] = sum;
    end
  endtask

  task automatic expect_zero();
    for (int h = 0; h < `MAC_HEIGHT; h++) z_exp[h] = '0;
  endtask

  task automatic check_z(input string tag);
    logic [31:0] z;
    for (int h = 0; h < `MAC_HEIGHT; h++) begin
      wb_read(`REG_Z0 + h, z);
      check(z, z_exp[h], $sformatf("%s, Z%0d", tag, h));
    end
  endtask

  task automatic read_reset_values();
    logic [31:0] v;
    wb_read(`REG_STATUS, v);
    check(v, 32'h0, "STATUS after reset");
    wb_read(`REG_CFG, v);
    check(v, 32'h0, "CFG after reset");
    wb_read(`REG_X_LO, v);
    check(v, 32'h0, "X_LO after reset");
    expect_zero();
    check_z("reset");
    // Unmapped words read zero.
    wb_read(7, v);
    check(v, 32'h0, "unmapped word 7");
    wb_read(15, v);
    check(v, 32'h0, "unmapped word 15");
  endtask

  task automatic full_tile_product();
    logic [31:0] v;
    randomize_operands();
    // Extreme row and X values force the sum past 2^31.
    for (int d = 0; d < `MAC_DEPTH; d++) w_tile[0][d] = 16'h8000;
    for (int d = 1; d < `MAC_DEPTH; d++) x_vec[d] = 16'h8000;
    load_tile(`MAC_HEIGHT);
    set_x();
    run_and_wait();
    model_z(0, 0);
    check_z("full tile");
    // Done, not busy, row count wrapped.
    wb_read(`REG_STATUS, v);
    check(v, 32'h2, "STATUS after full tile");
  endtask

  task automatic leftover_product();
    logic [31:0] v;
    randomize_operands();
    wb_write(`REG_CFG, (3 << 8) | 2);
    wb_read(`REG_CFG, v);
    check(v, 32'h302, "CFG readback");
    load_tile(`MAC_HEIGHT);
    set_x();
    run_and_wait();
    model_z(2, 3);
    check_z("leftover tile");
    wb_write(`REG_CFG, 32'h0);
  endtask

  task automatic clear_then_run();
    logic [31:0] v;
    randomize_operands();
    load_tile(2);
    wb_read(`REG_STATUS, v);
    check(32'(v[6:4]), 32'd2, "row count after two loads");
    wb_write(`REG_CTRL, 32'h2);
    wb_read(`REG_STATUS, v);
    check(32'(v[6:4]), 32'd0, "row count after clear");
    run_and_wait();
    expect_zero();
    check_z("after clear");
  endtask

  task automatic drained_rerun();
    logic [31:0] v;
    randomize_operands();
    load_tile(`MAC_HEIGHT);
    set_x();
    run_and_wait();
    model_z(0, 0);
    check_z("first run");
    // Second start, with a row write that lands while busy.
    wb_write(`REG_CTRL, 32'h1);
    wb_write(`REG_W_HI, 32'h7fff7fff);
    wait_done();
    expect_zero();
    check_z("drained run");
    // Four loads wrapped the row counter, the dropped write leaves it there.
    wb_read(`REG_STATUS, v);
    check(32'(v[6:4]), 32'd0, "row count after busy W_HI write");
    run_and_wait();
    check_z("run after dropped load");
  endtask

  task automatic start_while_busy();
    logic [31:0] v;
    randomize_operands();
    load_tile(`MAC_HEIGHT);
    set_x();
    wb_write(`REG_CTRL, 32'h1);
    wb_write(`REG_CTRL, 32'h1);
    wait_done();
    model_z(0, 0);
    check_z("start while busy");
    // No second run follows the ignored start.
    repeat (2) begin
      wb_read(`REG_STATUS, v);
      check(v, 32'h2, "STATUS after ignored start");
    end
  endtask

  initial begin
    void'($urandom(32'hbdd85051));
    errors   = 0;
    rst_ni   = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = 4'hf;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    read_reset_values();
    full_tile_product();
    leftover_product();
    clear_then_run();
    drained_rerun();
    start_while_busy();

    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+hw
hw/gemm_pkg.sv
hw/gemm_w_buffer.sv
hw/gemm_mac_array.sv
hw/gemm_ctrl.sv
hw/gemm_wb_regs.sv
hw/gemm_top.sv
bench/gemm_tb.sv

//--- Bender.yml
package:
  name: gemm_tile

sources:
  - include_dirs:
      - hw
    files:
      - hw/gemm_pkg.sv
      - hw/gemm_w_buffer.sv
      - hw/gemm_mac_array.sv
      - hw/gemm_ctrl.sv
      - hw/gemm_wb_regs.sv
      - hw/gemm_top.sv
      - target: test
        files:
          - bench/gemm_tb.sv
